//--- Bender.yml
package:
  name: rv_alu_stage

sources:
  - design/rv_pkg.sv
  - design/rv_adder.sv
  - design/rv_bitwise.sv
  - design/rv_muldiv.sv
  - design/rv_result_mux.sv
  - design/rv_store_lanes.sv
  - design/rv_alu_stage.sv
  - target: test
    files:
      - bench/tb_alu_stage.sv

//--- bench/alu_input_vectors.txt
# name grp f3 ctl flags rd op1 op2 reg_data2 pc_next pc_target flush, then expected
# result pc_select wdata wsel (hex; ctl = inv,sra,div,ovr; flags = rw,st,jmp,br,link,mem)
add       0 0 0 20 01 00001234 00000ff0 00000000 0000 0000 0 00002224 0 00000000 0
sub       0 0 8 20 02 00000005 00000007 00000000 0000 0000 0 fffffffe 0 00000000 0
slt       0 2 8 20 03 ffffffff 00000001 00000000 0000 0000 0 00000001 0 00000000 0
sltu      0 3 8 20 04 ffffffff 00000001 00000000 0000 0000 0 00000000 0 00000000 0
xor       1 4 0 20 05 f0f0f0f0 0ff00ff0 00000000 0000 0000 0 ff00ff00 0 00000000 0
or        1 6 0 20 06 12340000 00005678 00000000 0000 0000 0 12345678 0 00000000 0
and       1 7 0 20 07 f0f0f0f0 0ff00ff0 00000000 0000 0000 0 00f000f0 0 00000000 0
sll       1 1 0 20 08 00000001 0000003f 00000000 0000 0000 0 80000000 0 00000000 0
srl       1 5 0 20 09 80000000 00000004 00000000 0000 0000 0 08000000 0 00000000 0
sra       1 5 4 20 0a 80000000 00000004 00000000 0000 0000 0 f8000000 0 00000000 0
mul       2 0 0 20 0b fffffffd 00000007 00000000 0000 0000 0 ffffffeb 0 00000000 0
mulh      2 1 0 20 0c 80000000 00000003 00000000 0000 0000 0 fffffffe 0 00000000 0
mulhsu    2 2 0 20 0d ffffffff ffffffff 00000000 0000 0000 0 ffffffff 0 00000000 0
mulhu     2 3 0 20 0e ffffffff ffffffff 00000000 0000 0000 0 fffffffe 0 00000000 0
div       2 4 2 20 0f fffffff9 00000002 00000000 0000 0000 0 fffffffd 0 00000000 0
divu      2 5 2 20 10 00000064 00000007 00000000 0000 0000 0 0000000e 0 00000000 0
rem       2 6 2 20 11 fffffff9 00000002 00000000 0000 0000 0 ffffffff 0 00000000 0
remu      2 7 2 20 12 00000064 00000007 00000000 0000 0000 0 00000002 0 00000000 0
div_zero  2 4 2 20 13 00001234 00000000 00000000 0000 0000 0 ffffffff 0 00000000 0
rem_zero  2 6 2 20 14 00001234 00000000 00000000 0000 0000 0 00001234 0 00000000 0
div_ovf   2 4 2 20 15 80000000 ffffffff 00000000 0000 0000 0 80000000 0 00000000 0
beq       0 0 8 04 00 0000002a 0000002a 00000000 0104 0200 0 00000000 1 00000000 0
bne       0 1 8 04 00 00000005 00000005 00000000 0108 0300 0 00000000 0 00000000 0
blt       0 4 8 04 00 fffffffe 00000001 00000000 010c 0400 0 fffffffd 1 00000000 0
bge       0 5 8 04 00 fffffffe 00000001 00000000 0110 0500 0 fffffffd 0 00000000 0
bltu      0 6 8 04 00 fffffffe 00000001 00000000 0114 0600 0 fffffffd 0 00000000 0
bgeu      0 7 8 04 00 fffffffe 00000001 00000000 0118 0700 0 fffffffd 1 00000000 0
jal       0 0 0 2a 01 00000100 00000040 00000000 0104 0140 0 00000140 1 00000000 0
jalr      0 0 0 2a 05 00000300 00000008 00000000 0208 0308 0 00000308 1 00000000 0
sb_0      3 0 0 10 00 00001000 00000000 000000a5 0000 0000 0 00001000 0 a5a5a5a5 1
sb_1      3 0 0 10 00 00001001 00000000 0000007e 0000 0000 0 00001001 0 7e7e7e7e 2
sb_2      3 0 0 10 00 00000fff 00000003 00000011 0000 0000 0 00001002 0 11111111 4
sb_3      3 0 0 10 00 00001000 00000003 123456c3 0000 0000 0 00001003 0 c3c3c3c3 8
sh_0      3 1 0 10 00 00002000 00000000 abcdbeef 0000 0000 0 00002000 0 beefbeef 3
sh_2      3 1 0 10 00 00002000 00000002 00001234 0000 0000 0 00002002 0 12341234 c
sw        3 2 0 10 00 00003000 00000004 deadbeef 0000 0000 0 00003004 0 deadbeef f
div_flush 2 4 2 20 16 00000064 00000007 00000000 0000 0000 1 0000000e 0 00000000 0
div_after 2 4 2 20 17 ffffff9c 00000007 00000000 0000 0000 0 fffffff2 0 00000000 0

//--- bench/tb_alu_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_alu_stage;

    localparam int WAIT_LIMIT = 40;

    logic               i_clk = 1'b0;
    logic               i_rst_n;
    logic               i_flush;
    rv_pkg::exec_req_t  i_req;
    logic               o_ready;
    rv_pkg::wb_t        o_wb;
    rv_pkg::mem_req_t   o_mem;
    logic               o_pc_select;
    rv_pkg::pc_t        o_pc_target;

    logic [15:0]        lfsr;
    int                 test_err;
    int                 n_pass;
    int                 n_fail;

    rv_alu_stage dut_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_flush),
        .i_req       (i_req),
        .o_ready     (o_ready),
        .o_wb        (o_wb),
        .o_mem       (o_mem),
        .o_pc_select (o_pc_select),
        .o_pc_target (o_pc_target)
    );

    always #10 i_clk = ~i_clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_gap(output int gap);
        gap = 0;
        for (int i = 0; i < 2; i++)
        begin
            lfsr = lfsr_next(lfsr);
            gap  = (gap << 1) | lfsr[0];
        end
    endtask

    task automatic check_value(input string tname, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("FAILED %s: %s expected %h actual %h", tname, field, exp, act);
            test_err++;
        end
    endtask

    // sampled at negedge away from the driving edge
    task automatic wait_ready(input string tname, output int cycles,
                              output logic timed_out);
        cycles    = 0;
        timed_out = 1'b0;
        @(negedge i_clk);
        while (!o_ready && cycles < WAIT_LIMIT)
        begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_ready)
        begin
            $display("%s: stage did not become ready within %0d cycles", tname, WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    initial
    begin
        int                 fd;
        int                 n;
        int                 gap;
        int                 waited;
        int                 exp_wait;
        logic               timed_out;
        string              tname;
        logic [1023:0]      skip_buf;
        logic [3:0]         grp, f3, ctl, flush_f, exp_sel, exp_wsel;
        logic [7:0]         flags, rd_v;
        logic [31:0]        op1, op2, rd2, exp_res, exp_wdata;
        logic [15:0]        pcn, pct;
        rv_pkg::exec_req_t  req;

        i_rst_n = 1'b0;
        i_flush = 1'b0;
        i_req   = '0;
        lfsr    = 16'd78;
        n_pass  = 0;
        n_fail  = 0;
        repeat (5) @(posedge i_clk);
        i_rst_n <= 1'b1;

        fd = $fopen("bench/alu_input_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the vector file");
            n_fail++;
        end

        while (fd != 0 && !$feof(fd))
        begin
            n = $fscanf(fd, "%s", tname);
            if (n != 1)
                break;
            if (tname == "#")
            begin
                n = $fgets(skip_buf, fd);
                continue;
            end
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        grp, f3, ctl, flags, rd_v, op1, op2, rd2, pcn, pct, flush_f,
                        exp_res, exp_sel, exp_wdata, exp_wsel);
            if (n != 15)
            begin
                $display("%s: vector line has %0d fields instead of 15", tname, n);
                n_fail++;
                break;
            end

            req                       = '0;
            req.alu_ctrl.group        = rv_pkg::alu_group_e'(grp[1:0]);
            req.alu_ctrl.op2_inverse  = ctl[3];
            req.alu_ctrl.sh_ar        = ctl[2];
            req.alu_ctrl.div_mux      = ctl[1];
            req.alu_ctrl.add_override = ctl[0];
            req.funct3                = f3[2:0];
            req.reg_write             = flags[5];
            req.store                 = flags[4];
            req.jal_jalr              = flags[3];
            req.branch                = flags[2];
            req.res_src.pc_next       = flags[1];
            req.res_src.mem           = flags[0];
            req.rd                    = rd_v[4:0];
            req.op1                   = op1;
            req.op2                   = op2;
            req.reg_data2             = rd2;
            req.pc_next               = pcn[15:1];
            req.pc_target             = pct[15:1];

            draw_gap(gap);
            repeat (gap) @(posedge i_clk);
            @(posedge i_clk);
            i_req <= req;
            @(posedge i_clk);   // the stage is ready so this edge captures
            i_req <= '0;

            if (flush_f[0])
            begin
                repeat (3) @(posedge i_clk);
                i_flush <= 1'b1;
                @(posedge i_clk);
                i_flush <= 1'b0;
            end
            wait_ready(tname, waited, timed_out);
            if (timed_out)
            begin
                n_fail++;
                break;
            end

            // mul/div stalls for the whole loop unless flushed
            exp_wait = (grp[1:0] == 2'd2 && !flush_f[0]) ? rv_pkg::MD_STEPS : 0;

            test_err = 0;
            check_value(tname, "wait_cycles", exp_wait, waited);
            if (flush_f[0])
            begin
                check_value(tname, "reg_write", 32'd0, o_wb.reg_write);
                check_value(tname, "pc_select", exp_sel, o_pc_select);
            end
            else
            begin
                check_value(tname, "result", exp_res, o_wb.result);
                check_value(tname, "pc_select", exp_sel, o_pc_select);
                check_value(tname, "reg_write", flags[5], o_wb.reg_write);
                check_value(tname, "rd", rd_v[4:0], o_wb.rd);
                check_value(tname, "res_src", flags[1:0], o_wb.res_src);
                check_value(tname, "is_ext", flags[1], o_wb.is_ext);
                check_value(tname, "store", flags[4], o_mem.store);
                if (exp_sel[0])
                    check_value(tname, "pc_target", {16'h0, pct[15:1], 1'b0},
                                {16'h0, o_pc_target, 1'b0});
                if (flags[3])   // link value
                    check_value(tname, "ext_data", {16'h0, pcn[15:1], 1'b0}, o_wb.ext_data);
                if (flags[4])
                begin
                    check_value(tname, "addr", exp_res, o_mem.addr);
                    check_value(tname, "wdata", exp_wdata, o_mem.wdata);
                    check_value(tname, "wsel", exp_wsel, o_mem.wsel);
                    check_value(tname, "mem_funct3", f3[2:0], o_mem.funct3);
                end
            end

            if (test_err == 0)
            begin
                $display("pass   %s", tname);
                n_pass++;
            end
            else
                n_fail++;
        end
        if (fd != 0)
            $fclose(fd);

        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0 && n_pass > 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/rv_adder.sv
`timescale 1ns/1ns
`default_nettype none

module rv_adder
(
    input  wire logic           i_is_sub,
    input  wire logic           i_cmp_inverse,
    input  wire logic [32:0]    i_op1,
    input  wire rv_pkg::word_t  i_op2,
    output logic [32:0]         o_add,
    output logic                o_eq,
    output logic                o_lts,
    output logic                o_ltu
);

    logic [32:0] op2_ext;
    logic        lts_raw;

    // ones' complement plus carry in for subtract
    assign op2_ext = {i_is_sub, i_op2 ^ {32{i_is_sub}}};
    assign o_add   = i_op1 + op2_ext + 33'(i_is_sub);

    // borrow decides unless the signs differ
    assign lts_raw = (i_op1[31] ^ i_op2[31]) ? i_op1[31] : o_add[32];

    // inverted sense covers bne/bge/bgeu
    assign o_eq  = (o_add[31:0] == '0) ^ i_cmp_inverse;
    assign o_lts = lts_raw ^ i_cmp_inverse;
    assign o_ltu = o_add[32] ^ i_cmp_inverse;  // borrow out

endmodule

`default_nettype wire

//--- design/rv_alu_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rv_alu_stage
(
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_flush,
    input  wire rv_pkg::exec_req_t  i_req,
    output logic                    o_ready,
    output rv_pkg::wb_t             o_wb,
    output rv_pkg::mem_req_t        o_mem,
    output logic                    o_pc_select,
    output rv_pkg::pc_t             o_pc_target
);

    rv_pkg::exec_req_t  req_r;
    rv_pkg::alu_state_e state, state_next;
    logic [5:0]         step_cnt;
    logic               md_grp, is_sub, cmp_inv, cmp_result;
    logic               eq, lts, ltu;
    logic [32:0]        add_op1, add, shr, add_prev;
    rv_pkg::word_t      add_op2, md_mod, md_result;
    rv_pkg::word_t      xor_res, or_res, and_res, shl_res, alu_result;
    rv_pkg::word_t      wdata;
    logic [3:0]         wsel;

    assign o_ready = (state != rv_pkg::ALU_WAIT);

    always_comb
    begin
        case (state)
        rv_pkg::ALU_START, rv_pkg::ALU_END:
            state_next = (i_req.alu_ctrl.group == rv_pkg::GRP_MULDIV) ?
                         rv_pkg::ALU_WAIT : rv_pkg::ALU_START;
        rv_pkg::ALU_WAIT:
            state_next = (step_cnt == 6'(rv_pkg::MD_STEPS - 1)) ?
                         rv_pkg::ALU_END : rv_pkg::ALU_WAIT;
        default:
            state_next = rv_pkg::ALU_START;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_flush)
        begin
            state    <= rv_pkg::ALU_START;
            step_cnt <= '0;
        end
        else
        begin
            state    <= state_next;
            step_cnt <= (state == rv_pkg::ALU_WAIT) ? step_cnt + 6'd1 : 6'd0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_flush)
        begin
            req_r.reg_write <= 1'b0;
            req_r.store     <= 1'b0;
            req_r.jal_jalr  <= 1'b0;
            req_r.branch    <= 1'b0;
            req_r.res_src   <= '0;
        end
        else if (o_ready)
            req_r <= i_req;
    end

    // adder shared with the mul/div loop
    assign md_grp  = (req_r.alu_ctrl.group == rv_pkg::GRP_MULDIV);
    assign is_sub  = md_grp ? req_r.alu_ctrl.div_mux : req_r.alu_ctrl.op2_inverse;
    assign add_op1 = md_grp ? add_prev : {1'b0, req_r.op1};
    assign add_op2 = md_grp ? md_mod : req_r.op2;
    assign cmp_inv = req_r.funct3[0] & req_r.branch;

    rv_adder u_adder (
        .i_is_sub       (is_sub),
        .i_cmp_inverse  (cmp_inv),
        .i_op1          (add_op1),
        .i_op2          (add_op2),
        .o_add          (add),
        .o_eq           (eq),
        .o_lts          (lts),
        .o_ltu          (ltu)
    );

    rv_bitwise u_bitwise (
        .i_sra  (req_r.alu_ctrl.sh_ar),
        .i_op1  (req_r.op1),
        .i_op2  (req_r.op2),
        .o_xor  (xor_res),
        .o_or   (or_res),
        .o_and  (and_res),
        .o_shl  (shl_res),
        .o_shr  (shr)
    );

    rv_muldiv u_muldiv (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_on_wait  (state == rv_pkg::ALU_WAIT),
        .i_on_end   (state == rv_pkg::ALU_END),
        .i_is_div   (req_r.alu_ctrl.div_mux),
        .i_funct3   (req_r.funct3),
        .i_op1      (req_r.op1),
        .i_op2      (req_r.op2),
        .i_add      (add),
        .o_mod      (md_mod),
        .o_add_prev (add_prev),
        .o_result   (md_result)
    );

    rv_result_mux u_result_mux (
        .i_group        (req_r.alu_ctrl.group),
        .i_funct3       (req_r.funct3),
        .i_add_override (req_r.alu_ctrl.add_override),
        .i_add          (add[31:0]),
        .i_xor          (xor_res),
        .i_or           (or_res),
        .i_and          (and_res),
        .i_shl          (shl_res),
        .i_shr          (shr[31:0]),
        .i_md           (md_result),
        .i_lts          (lts),
        .i_ltu          (ltu),
        .o_out          (alu_result)
    );

    rv_store_lanes u_store_lanes (
        .i_funct3       (req_r.funct3[1:0]),
        .i_addr_lo      (add[1:0]),
        .i_reg_data2    (req_r.reg_data2),
        .o_wdata        (wdata),
        .o_wsel         (wsel)
    );

    always_comb
    begin
        case (req_r.funct3[2:1])
        2'b00  : cmp_result = eq;   // beq/bne
        2'b10  : cmp_result = lts;
        default: cmp_result = ltu;
        endcase
    end

    assign o_pc_select = (req_r.jal_jalr | (req_r.branch & cmp_result)) & !i_flush;
    assign o_pc_target = req_r.pc_target;

    always_comb
    begin
        o_wb.result    = alu_result;
        o_wb.ext_data  = req_r.res_src.pc_next ?
                         {{(rv_pkg::XLEN - rv_pkg::PC_BITS){1'b0}}, req_r.pc_next, 1'b0} : '0;
        o_wb.is_ext    = req_r.res_src.pc_next;   // link value for jumps
        o_wb.rd        = req_r.rd;
        o_wb.reg_write = req_r.reg_write;
        o_wb.res_src   = req_r.res_src;
        o_mem.store    = req_r.store;
        o_mem.addr     = add[31:0];
        o_mem.wdata    = wdata;
        o_mem.wsel     = wsel;
        o_mem.funct3   = req_r.funct3;
    end

    a_stall_md: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_ready |-> (state == rv_pkg::ALU_WAIT) && md_grp);

    a_cnt_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        step_cnt <= 6'(rv_pkg::MD_STEPS));

    // halfword store never straddles the word
    a_half_align: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (req_r.store && (req_r.funct3[1:0] == 2'b01)) |-> (add[1:0] != 2'b11));

endmodule

`default_nettype wire

//--- design/rv_bitwise.sv
`timescale 1ns/1ns
`default_nettype none

module rv_bitwise
(
    input  wire logic           i_sra,
    input  wire rv_pkg::word_t  i_op1,
    input  wire rv_pkg::word_t  i_op2,
    output rv_pkg::word_t       o_xor,
    output rv_pkg::word_t       o_or,
    output rv_pkg::word_t       o_and,
    output rv_pkg::word_t       o_shl,
    output logic [32:0]         o_shr
);

    logic [4:0]  shamt;
    logic [32:0] shr_src;

    assign shamt = i_op2[4:0];

    assign o_xor = i_op1 ^ i_op2;
    assign o_or  = i_op1 | i_op2;
    assign o_and = i_op1 & i_op2;

    assign o_shl = i_op1 << shamt;

    // one extra bit carries the sign for sra, zero for srl
    assign shr_src = {i_sra & i_op1[31], i_op1};
    assign o_shr   = $signed(shr_src) >>> shamt;

endmodule

`default_nettype wire

//--- design/rv_muldiv.sv
`timescale 1ns/1ns
`default_nettype none

module rv_muldiv
(
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_on_wait,
    input  wire logic             i_on_end,
    input  wire logic             i_is_div,
    input  wire rv_pkg::funct3_t  i_funct3,
    input  wire rv_pkg::word_t    i_op1,
    input  wire rv_pkg::word_t    i_op2,
    input  wire logic [32:0]      i_add,
    output rv_pkg::word_t         o_mod,
    output logic [32:0]           o_add_prev,
    output rv_pkg::word_t         o_result
);

    rv_pkg::word_t hi_q, lo_q;      // product, or remainder and quotient
    rv_pkg::word_t cur_hi, cur_lo;
    rv_pkg::word_t a_mag, b_mag, quo, rem;
    logic [63:0]   prod, prod_fix;
    logic          running, first;
    logic          a_signed, b_signed, a_neg, b_neg, res_neg;

    assign a_signed = i_is_div ? !i_funct3[0] : (i_funct3[1:0] != 2'b11);
    assign b_signed = i_is_div ? !i_funct3[0] : !i_funct3[1];
    assign a_neg    = a_signed & i_op1[31];
    assign b_neg    = b_signed & i_op2[31];
    assign a_mag    = a_neg ? -i_op1 : i_op1;
    assign b_mag    = b_neg ? -i_op2 : i_op2;

    // first wait cycle starts from the operands, not the registers
    assign first  = i_on_wait & !running;
    assign cur_hi = first ? '0 : hi_q;
    assign cur_lo = first ? a_mag : lo_q;

    always_comb
    begin
        if (i_is_div)
        begin
            o_add_prev = {cur_hi, cur_lo[31]};  // shifted remainder
            o_mod      = b_mag;
        end
        else
        begin
            o_add_prev = {1'b0, cur_hi};
            o_mod      = cur_lo[0] ? b_mag : '0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            running <= 1'b0;
        else
            running <= i_on_wait;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_on_wait)
        begin
            if (!i_is_div)
            begin
                hi_q <= i_add[32:1];
                lo_q <= {i_add[0], cur_lo[31:1]};
            end
            else if (!i_add[32])    // no borrow, keep difference
            begin
                hi_q <= i_add[31:0];
                lo_q <= {cur_lo[30:0], 1'b1};
            end
            else
            begin
                hi_q <= {cur_hi[30:0], cur_lo[31]};
                lo_q <= {cur_lo[30:0], 1'b0};
            end
        end
    end

    // sign restore at end
    assign res_neg  = i_on_end & (a_neg ^ b_neg);
    assign prod     = {hi_q, lo_q};
    assign prod_fix = res_neg ? -prod : prod;
    assign quo      = res_neg ? -lo_q : lo_q;
    assign rem      = (i_on_end & a_neg) ? -hi_q : hi_q;  // follows dividend

    always_comb
    begin
        if (i_is_div && (i_op2 == '0))
            o_result = i_funct3[1] ? i_op1 : '1;
        else if (i_is_div)
            o_result = i_funct3[1] ? rem : quo;
        else if (i_funct3[1:0] == 2'b00)
            o_result = prod_fix[31:0];
        else
            o_result = prod_fix[63:32];
    end

    a_wait_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_on_wait [*rv_pkg::MD_STEPS] |=> !i_on_wait);

endmodule

`default_nettype wire

//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN     = 32;
    localparam int PC_BITS  = 16;   // instruction address space
    localparam int MD_STEPS = 32;   // mul/div iterations

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [4:0]         reg_idx_t;
    typedef logic [PC_BITS-1:1] pc_t;       // halfword aligned
    typedef logic [2:0]         funct3_t;

    typedef enum logic [1:0] {
        GRP_ARITH,      // add/sub/slt
        GRP_LOGIC,      // xor/or/and/shifts
        GRP_MULDIV,
        GRP_PASS        // load/store address
    } alu_group_e;

    typedef struct packed {
        alu_group_e group;
        logic       op2_inverse;
        logic       sh_ar;
        logic       div_mux;
        logic       add_override;
    } alu_ctrl_t;

    typedef struct packed {
        logic pc_next;
        logic mem;
    } res_src_t;

    typedef enum logic [1:0] {
        ALU_START,
        ALU_WAIT,
        ALU_END
    } alu_state_e;

    typedef struct packed {
        word_t     op1;
        word_t     op2;
        word_t     reg_data2;
        reg_idx_t  rd;
        logic      reg_write;
        logic      store;
        logic      jal_jalr;
        logic      branch;
        pc_t       pc_next;
        pc_t       pc_target;
        res_src_t  res_src;
        funct3_t   funct3;
        alu_ctrl_t alu_ctrl;
    } exec_req_t;

    typedef struct packed {
        word_t    result;
        word_t    ext_data;
        logic     is_ext;
        reg_idx_t rd;
        logic     reg_write;
        res_src_t res_src;
    } wb_t;

    typedef struct packed {
        logic    store;
        word_t   addr;
        word_t   wdata;
        logic [3:0] wsel;
        funct3_t funct3;
    } mem_req_t;

endpackage

`default_nettype wire

//--- design/rv_result_mux.sv
`timescale 1ns/1ns
`default_nettype none

module rv_result_mux
(
    input  wire rv_pkg::alu_group_e i_group,
    input  wire rv_pkg::funct3_t    i_funct3,
    input  wire logic               i_add_override,
    input  wire rv_pkg::word_t      i_add,
    input  wire rv_pkg::word_t      i_xor,
    input  wire rv_pkg::word_t      i_or,
    input  wire rv_pkg::word_t      i_and,
    input  wire rv_pkg::word_t      i_shl,
    input  wire rv_pkg::word_t      i_shr,
    input  wire rv_pkg::word_t      i_md,
    input  wire logic               i_lts,
    input  wire logic               i_ltu,
    output rv_pkg::word_t           o_out
);

    always_comb
    begin
        o_out = i_add;
        if (!i_add_override)  // lui/auipc keep the sum
        begin
            case (i_group)
            rv_pkg::GRP_ARITH:
                case (i_funct3)
                3'b010 : o_out = {31'b0, i_lts};
                3'b011 : o_out = {31'b0, i_ltu};
                default: o_out = i_add;
                endcase
            rv_pkg::GRP_LOGIC:
                case (i_funct3)
                3'b001 : o_out = i_shl;
                3'b100 : o_out = i_xor;
                3'b101 : o_out = i_shr;
                3'b110 : o_out = i_or;
                default: o_out = i_and;
                endcase
            rv_pkg::GRP_MULDIV: o_out = i_md;
            default           : o_out = i_add;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/rv_store_lanes.sv
`timescale 1ns/1ns
`default_nettype none

module rv_store_lanes
(
    input  wire logic [1:0]     i_funct3,   // access size
    input  wire logic [1:0]     i_addr_lo,
    input  wire rv_pkg::word_t  i_reg_data2,
    output rv_pkg::word_t       o_wdata,
    output logic [3:0]          o_wsel
);

    always_comb
    begin
        case (i_funct3)
        2'b00:
        begin
            o_wdata = {4{i_reg_data2[7:0]}};
            o_wsel  = 4'b0001 << i_addr_lo;
        end
        2'b01:
        begin
            o_wdata = {2{i_reg_data2[15:0]}};
            o_wsel  = i_addr_lo[1] ? 4'b1100 : 4'b0011;  // upper or lower half
        end
        default:
        begin
            o_wdata = i_reg_data2;
            o_wsel  = 4'b1111;
        end
        endcase
    end

endmodule

`default_nettype wire

//--- sources.f
design/rv_pkg.sv
design/rv_adder.sv
design/rv_bitwise.sv
design/rv_muldiv.sv
design/rv_result_mux.sv
design/rv_store_lanes.sv
design/rv_alu_stage.sv
bench/tb_alu_stage.sv
